// ==== common/issue_pkg.sv ====
package issue_pkg;

	// Machine word and register file geometry
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 1 << REG_ADDR_W;
	localparam int ALU_FN_W   = 4;
	localparam int SHAMT_W    = 5;

	typedef logic [XLEN-1:0]       xlen_t;
	typedef logic [XLEN-1:0]       pc_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [ALU_FN_W-1:0]   alu_fn_t;

	// Source of operand B at execute
	typedef enum logic [1:0]
	{
		BSEL_REG   = 2'd0,
		BSEL_IMM   = 2'd1,
		BSEL_SHAMT = 2'd2
	} bsel_e;

	// One decoded instruction as handed over by decode
	typedef struct packed
	{
		reg_addr_t          rs1;
		reg_addr_t          rs2;
		reg_addr_t          rd;
		logic               we;
		bsel_e              bsel;
		alu_fn_t            alu_fn;
		logic [2:0]         fn3;
		xlen_t              i_imm;
		xlen_t              b_imm;
		logic [SHAMT_W-1:0] shamt;
		logic               branch;
		pc_t                pc;
	} dec_bundle_t;

	// Issued instruction with final operands
	typedef struct packed
	{
		reg_addr_t  rd;
		logic       we;
		alu_fn_t    alu_fn;
		logic [2:0] fn3;
		xlen_t      op_a;
		xlen_t      op_b;
		xlen_t      b_imm;
		pc_t        pc;
		logic       branch;
	} iss_bundle_t;

	// Register write from commit
	typedef struct packed
	{
		logic      we;
		reg_addr_t rd;
		xlen_t     data;
	} wb_bundle_t;

endpackage

// ==== hdl/regfile.sv ====
module regfile (
	input  logic                  clk,
	input  logic                  nrst,
	input  issue_pkg::wb_bundle_t wb,
	input  issue_pkg::reg_addr_t  rs1,
	input  issue_pkg::reg_addr_t  rs2,
	output issue_pkg::xlen_t      rdata1,
	output issue_pkg::xlen_t      rdata2
);

	// x0 has no storage
	issue_pkg::xlen_t regs [1:issue_pkg::NUM_REGS-1];
	logic             wr_en;

	// Write-first read where a same-cycle writeback wins over the stored value
	function automatic issue_pkg::xlen_t read_port(input issue_pkg::reg_addr_t addr);
		issue_pkg::xlen_t val;
		if (addr == '0)
			val = '0;
		else if (wr_en && (wb.rd == addr))
			val = wb.data;
		else
			val = regs[addr];
		return val;
	endfunction

	assign wr_en = wb.we && (wb.rd != '0);

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 1; i < issue_pkg::NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (wr_en)
		begin
			regs[wb.rd] <= wb.data;
		end
	end

	always_comb
	begin
		rdata1 = read_port(rs1);
		rdata2 = read_port(rs2);
	end

endmodule

// ==== issue_stage/scoreboard.sv ====
module scoreboard #(
	parameter int KILL_SLOTS = 2
) (
	input  logic                   clk,
	input  logic                   nrst,
	input  logic                   dec_valid,
	input  issue_pkg::dec_bundle_t dec,
	input  issue_pkg::wb_bundle_t  wb,
	input  logic                   br_taken,
	output logic                   stall,
	output logic                   kill
);

	// Enough bits to hold KILL_SLOTS-1, at least one
	localparam int CNT_W = $clog2(KILL_SLOTS + 1);

	// Bit 0 stays clear since x0 is never a destination
	logic [issue_pkg::NUM_REGS-1:0] busy;
	logic [CNT_W-1:0]               kill_cnt;

	logic wb_hit;
	logic haz_rs1;
	logic haz_rs2;
	logic issue;
	logic mark;

	assign wb_hit = wb.we && (wb.rd != '0);

	// A source is blocked only if busy and not being written back right now
	assign haz_rs1 = (dec.rs1 != '0) && busy[dec.rs1] &&
		!(wb_hit && (wb.rd == dec.rs1));
	assign haz_rs2 = (dec.rs2 != '0) && busy[dec.rs2] &&
		!(wb_hit && (wb.rd == dec.rs2));

	assign stall = dec_valid && (haz_rs1 || haz_rs2);

	// Squash window starts in the br_taken cycle itself
	assign kill = br_taken || (kill_cnt != '0);

	// Instruction actually enters the issue register
	assign issue = dec_valid && !stall && !kill;
	assign mark  = issue && dec.we && (dec.rd != '0);

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			busy <= '0;
		end
		else
		begin
			if (wb_hit)
				busy[wb.rd] <= 1'b0;
			// New writer to the same rd keeps the entry busy
			if (mark)
				busy[dec.rd] <= 1'b1;
		end
	end

	// Counts the remaining squashed slots after the branch cycle
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			kill_cnt <= '0;
		end
		else if (br_taken)
		begin
			kill_cnt <= CNT_W'(KILL_SLOTS - 1);
		end
		else if (kill_cnt != '0)
		begin
			kill_cnt <= kill_cnt - 1'b1;
		end
	end

endmodule

// ==== issue_stage/issue_stage.sv ====
module issue_stage (
	input  logic                   clk,
	input  logic                   nrst,
	input  logic                   dec_valid,
	input  issue_pkg::dec_bundle_t dec,
	input  issue_pkg::xlen_t       rdata1,
	input  issue_pkg::xlen_t       rdata2,
	input  logic                   stall,
	input  logic                   kill,
	output logic                   iss_valid,
	output issue_pkg::iss_bundle_t iss
);

	logic                   slot_ok;
	issue_pkg::xlen_t       op_b;
	issue_pkg::iss_bundle_t iss_d;

	// Registered stage state
	logic                   valid_q;
	logic                   we_q;
	logic                   branch_q;
	issue_pkg::iss_bundle_t payload_q;

	// Slot carries a real instruction only without stall or squash
	assign slot_ok = dec_valid && !stall && !kill;

	// Operand B mux ahead of the pipeline register
	always_comb
	begin
		case (dec.bsel)
			issue_pkg::BSEL_REG:
				op_b = rdata2;
			issue_pkg::BSEL_IMM:
				op_b = dec.i_imm;
			issue_pkg::BSEL_SHAMT:
				op_b = issue_pkg::xlen_t'(dec.shamt);
			default:
				op_b = rdata2;
		endcase
	end

	// Next issue bundle built from decode fields and register reads
	always_comb
	begin
		iss_d        = '0;
		iss_d.rd     = dec.rd;
		iss_d.we     = dec.we;
		iss_d.alu_fn = dec.alu_fn;
		iss_d.fn3    = dec.fn3;
		iss_d.op_a   = rdata1;
		iss_d.op_b   = op_b;
		iss_d.b_imm  = dec.b_imm;
		iss_d.pc     = dec.pc;
		iss_d.branch = dec.branch;
	end

	// Bubbles clear all three control bits of the slot
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			valid_q  <= 1'b0;
			we_q     <= 1'b0;
			branch_q <= 1'b0;
		end
		else
		begin
			valid_q  <= slot_ok;
			we_q     <= slot_ok && dec.we;
			branch_q <= slot_ok && dec.branch;
		end
	end

	// Payload only moves on a real issue
	always_ff @(posedge clk)
	begin
		if (slot_ok)
			payload_q <= iss_d;
	end

	// Drive execute with qualified control on top of the held payload
	always_comb
	begin
		iss        = payload_q;
		iss.we     = we_q;
		iss.branch = branch_q;
	end

	assign iss_valid = valid_q;

endmodule

// ==== hdl/issue_top.sv ====
module issue_top #(
	parameter int KILL_SLOTS = 2
) (
	input  logic                   clk,
	input  logic                   nrst,
	// Decode side
	input  logic                   dec_valid,
	input  issue_pkg::dec_bundle_t dec,
	output logic                   dec_ready,
	// Commit writeback
	input  issue_pkg::wb_bundle_t  wb,
	// Execute side
	input  logic                   br_taken,
	output logic                   iss_valid,
	output issue_pkg::iss_bundle_t iss
);

	issue_pkg::xlen_t rdata1;
	issue_pkg::xlen_t rdata2;
	logic             stall;
	logic             kill;

	// Decode is held only by a data hazard
	assign dec_ready = ~stall;

	regfile u_regfile (
		.clk    (clk),
		.nrst   (nrst),
		.wb     (wb),
		.rs1    (dec.rs1),
		.rs2    (dec.rs2),
		.rdata1 (rdata1),
		.rdata2 (rdata2)
	);

	scoreboard #(
		.KILL_SLOTS (KILL_SLOTS)
	) u_scoreboard (
		.clk       (clk),
		.nrst      (nrst),
		.dec_valid (dec_valid),
		.dec       (dec),
		.wb        (wb),
		.br_taken  (br_taken),
		.stall     (stall),
		.kill      (kill)
	);

	issue_stage u_issue_stage (
		.clk       (clk),
		.nrst      (nrst),
		.dec_valid (dec_valid),
		.dec       (dec),
		.rdata1    (rdata1),
		.rdata2    (rdata2),
		.stall     (stall),
		.kill      (kill),
		.iss_valid (iss_valid),
		.iss       (iss)
	);

endmodule

// ==== dv/issue_sva.sv ====
module issue_sva (
	input logic                   clk,
	input logic                   nrst,
	input logic                   dec_valid,
	input issue_pkg::dec_bundle_t dec,
	input logic                   dec_ready,
	input logic                   br_taken,
	input logic                   iss_valid,
	input logic                   iss_we
);

	timeunit 1ns;
	timeprecision 100ps;

	logic seen_xfer;
	int   fail_count = 0;

	// Set by the first decode transfer after reset
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			seen_xfer <= 1'b0;
		else if (dec_valid && dec_ready)
			seen_xfer <= 1'b1;
	end

	a_idle_until_xfer: assert property (@(posedge clk) disable iff (!nrst)
		!seen_xfer |-> !iss_valid)
	else
	begin
		fail_count++;
		$error("iss_valid high before any accepted decode transfer");
	end

	a_dec_held: assert property (@(posedge clk) disable iff (!nrst)
		(dec_valid && !dec_ready) |=> $stable(dec))
	else
	begin
		fail_count++;
		$error("Decode bundle changed while held by a stall");
	end

	a_squash_slot: assert property (@(posedge clk) disable iff (!nrst)
		br_taken |=> !iss_valid)
	else
	begin
		fail_count++;
		$error("Issue slot after a taken branch was not squashed");
	end

	a_bubble_no_we: assert property (@(posedge clk) disable iff (!nrst)
		!iss_valid |-> !iss_we)
	else
	begin
		fail_count++;
		$error("Write enable set in an empty issue slot");
	end

endmodule

bind issue_top issue_sva u_sva (
	.clk       (clk),
	.nrst      (nrst),
	.dec_valid (dec_valid),
	.dec       (dec),
	.dec_ready (dec_ready),
	.br_taken  (br_taken),
	.iss_valid (iss_valid),
	.iss_we    (iss.we)
);

// ==== dv/tb_issue.sv ====
module tb_issue;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 10;
	localparam int SLACK_CYCLES = 20;
	localparam int NUM_COLS     = 24;

	// Inputs and expected outputs of one stimulus line
	typedef struct packed
	{
		logic                   dec_valid;
		issue_pkg::dec_bundle_t dec;
		issue_pkg::wb_bundle_t  wb;
		logic                   br_taken;
		logic                   exp_ready;
		logic                   exp_valid;
		issue_pkg::reg_addr_t   exp_rd;
		logic                   exp_we;
		issue_pkg::xlen_t       exp_op_a;
		issue_pkg::xlen_t       exp_op_b;
		logic                   exp_branch;
	} stim_line_t;

	logic                   clk;
	logic                   nrst;
	logic                   dec_valid;
	issue_pkg::dec_bundle_t dec;
	logic                   dec_ready;
	issue_pkg::wb_bundle_t  wb;
	logic                   br_taken;
	logic                   iss_valid;
	issue_pkg::iss_bundle_t iss;

	stim_line_t vecs[$];
	string      names[$];
	int         cycle_count;
	int         cycle_limit;

	issue_top #(
		.KILL_SLOTS (2)
	) uut (
		.clk       (clk),
		.nrst      (nrst),
		.dec_valid (dec_valid),
		.dec       (dec),
		.dec_ready (dec_ready),
		.wb        (wb),
		.br_taken  (br_taken),
		.iss_valid (iss_valid),
		.iss       (iss)
	);

	always #50 clk = ~clk;

	// Run guard sized from the stimulus length
	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count > cycle_limit)
		begin
			$display("Timeout after %0d cycles before the stimulus was done", cycle_count);
			$display("Some tests failed");
			$fatal(1, "Simulation stopped by the cycle limit");
		end
	end

	task automatic check_value(input string test, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("CHECK FAILED: test %s, %s expected %h actual %h",
				test, what, expected, actual);
			$display("Some tests failed");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic load_stimulus();
		int          fd;
		int          rc;
		string       line;
		string       name;
		logic [31:0] col [NUM_COLS];
		stim_line_t  ln;
		fd = $fopen("dv/issue_stim.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open the stimulus file dv/issue_stim.txt");
			$display("Some tests failed");
			$fatal(1, "Missing stimulus file");
		end
		while (!$feof(fd))
		begin
			line = "";
			rc = $fgets(line, fd);
			// Blank lines and column notes
			if (rc == 0 || line.len() < 2 || line.substr(0, 0) == "#")
				continue;
			rc = $sscanf(line,
				"%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				name, col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
				col[8], col[9], col[10], col[11], col[12], col[13], col[14], col[15],
				col[16], col[17], col[18], col[19], col[20], col[21], col[22], col[23]);
			if (rc != NUM_COLS + 1)
			begin
				$display("Stimulus line has the wrong number of fields: %s", line);
				$display("Some tests failed");
				$fatal(1, "Malformed stimulus file");
			end
			ln            = '0;
			ln.dec_valid  = col[0][0];
			ln.dec.rs1    = col[1][4:0];
			ln.dec.rs2    = col[2][4:0];
			ln.dec.rd     = col[3][4:0];
			ln.dec.we     = col[4][0];
			ln.dec.bsel   = issue_pkg::bsel_e'(col[5][1:0]);
			ln.dec.alu_fn = col[6][3:0];
			ln.dec.fn3    = col[7][2:0];
			ln.dec.i_imm  = col[8];
			ln.dec.b_imm  = col[9];
			ln.dec.shamt  = col[10][4:0];
			ln.dec.branch = col[11][0];
			ln.dec.pc     = col[12];
			ln.wb.we      = col[13][0];
			ln.wb.rd      = col[14][4:0];
			ln.wb.data    = col[15];
			ln.br_taken   = col[16][0];
			ln.exp_ready  = col[17][0];
			ln.exp_valid  = col[18][0];
			ln.exp_rd     = col[19][4:0];
			ln.exp_we     = col[20][0];
			ln.exp_op_a   = col[21];
			ln.exp_op_b   = col[22];
			ln.exp_branch = col[23][0];
			vecs.push_back(ln);
			names.push_back(name);
		end
		$fclose(fd);
	endtask

	task automatic apply_line(input stim_line_t ln);
		dec_valid = ln.dec_valid;
		dec       = ln.dec;
		wb        = ln.wb;
		br_taken  = ln.br_taken;
	endtask

	task automatic check_outputs(input int idx);
		stim_line_t ln;
		stim_line_t prev;
		ln = vecs[idx];
		check_value(names[idx], "dec_ready", ln.exp_ready, dec_ready);
		check_value(names[idx], "iss_valid", ln.exp_valid, iss_valid);
		check_value(names[idx], "iss.we", ln.exp_we, iss.we);
		check_value(names[idx], "iss.branch", ln.exp_branch, iss.branch);
		// Payload only means something in a valid slot
		if (ln.exp_valid && idx > 0)
		begin
			prev = vecs[idx - 1];
			check_value(names[idx], "iss.rd", ln.exp_rd, iss.rd);
			check_value(names[idx], "iss.op_a", ln.exp_op_a, iss.op_a);
			check_value(names[idx], "iss.op_b", ln.exp_op_b, iss.op_b);
			// Pass-through fields come from the decode one line earlier
			check_value(names[idx], "iss.pc", prev.dec.pc, iss.pc);
			check_value(names[idx], "iss.b_imm", prev.dec.b_imm, iss.b_imm);
			check_value(names[idx], "iss.alu_fn", prev.dec.alu_fn, iss.alu_fn);
			check_value(names[idx], "iss.fn3", prev.dec.fn3, iss.fn3);
		end
	endtask

	task automatic check_assertions(input string test);
		if (uut.u_sva.fail_count != 0)
		begin
			$display("A protocol assertion failed during test %s", test);
			$display("Some tests failed");
			$fatal(1, "Stopped after an assertion failure");
		end
	endtask

	initial
	begin
		clk         = 1'b0;
		nrst        = 1'b0;
		dec_valid   = 1'b0;
		dec         = '0;
		wb          = '0;
		br_taken    = 1'b0;
		cycle_count = 0;
		cycle_limit = 0;

		load_stimulus();
		cycle_limit = names.size() + RESET_CYCLES + SLACK_CYCLES;

		// Valid hazard-free decode held during reset
		repeat (RESET_CYCLES)
		begin
			@(posedge clk);
			#1;
			dec_valid = 1'b1;
			dec       = '0;
			dec.rs1   = 5'd1;
			dec.rs2   = 5'd2;
			dec.pc    = 32'h100;
			#98;
			check_value("reset", "dec_ready", 1, dec_ready);
			check_value("reset", "iss_valid", 0, iss_valid);
		end

		for (int i = 0; i < names.size(); i++)
		begin
			@(posedge clk);
			#1;
			nrst = 1'b1;
			apply_line(vecs[i]);
			#98;
			check_outputs(i);
			check_assertions(names[i]);
		end

		// Assertions on the last driven line are evaluated at the next edge
		@(posedge clk);
		#1;
		if (uut.u_sva.fail_count == 0)
		begin
			$display("All tests passed");
			$finish;
		end
		else
		begin
			$display("A protocol assertion failed after the last stimulus line");
			$display("Some tests failed");
			$fatal(1, "Stopped after an assertion failure");
		end
	end

endmodule

// ==== dv/issue_stim.txt ====
# name valid rs1 rs2 rd we bsel alu fn3 i_imm b_imm shamt branch pc wb_we wb_rd wb_data br_taken
# expected: dec_ready iss_valid rd we op_a op_b branch (rd, op_a, op_b only in valid slots)
reset    1 01 02 00 0 0 0 0 00000000 0000 00 0 100 0 00 00000000 0 1 0 00 0 00000000 00000000 0
wb_read  0 00 00 00 0 0 0 0 00000000 0000 00 0 000 1 01 11111111 0 1 1 00 0 00000000 00000000 0
wb_read  0 00 00 00 0 0 0 0 00000000 0000 00 0 000 1 02 22222222 0 1 0 00 0 00000000 00000000 0
wb_read  1 01 02 00 0 0 2 0 00000000 0000 00 0 104 1 03 33333333 0 1 0 00 0 00000000 00000000 0
wb_read  1 04 03 00 0 0 2 0 00000000 0000 00 0 108 1 04 44444444 0 1 1 00 0 11111111 22222222 0
x0_write 1 00 00 00 0 0 0 0 00000000 0000 00 0 10c 1 00 ffffffff 0 1 1 00 0 44444444 33333333 0
x0_write 1 00 01 00 0 0 0 0 00000000 0000 00 0 110 0 00 00000000 0 1 1 00 0 00000000 00000000 0
opb_sel  1 02 03 00 0 1 1 0 00000abc 0000 00 0 114 0 00 00000000 0 1 1 00 0 00000000 11111111 0
opb_sel  1 02 03 00 0 2 5 1 00000abc 0000 1f 0 118 0 00 00000000 0 1 1 00 0 22222222 00000abc 0
opb_sel  1 01 03 00 0 0 0 0 00000abc 0000 1f 0 11c 0 00 00000000 0 1 1 00 0 22222222 0000001f 0
opb_sel  1 04 02 00 0 1 0 0 fffff800 0000 00 0 120 0 00 00000000 0 1 1 00 0 11111111 33333333 0
hazard   1 01 00 05 1 1 0 0 00000005 0000 00 0 124 0 00 00000000 0 1 1 00 0 44444444 fffff800 0
hazard   1 05 02 06 1 0 0 0 00000000 0000 00 0 128 0 00 00000000 0 0 1 05 1 11111111 00000005 0
hazard   1 05 02 06 1 0 0 0 00000000 0000 00 0 128 0 00 00000000 0 0 0 00 0 00000000 00000000 0
hazard   1 05 02 06 1 0 0 0 00000000 0000 00 0 128 1 05 55555555 0 1 0 00 0 00000000 00000000 0
hazard   1 05 00 00 0 0 0 0 00000000 0000 00 0 12c 0 00 00000000 0 1 1 06 1 55555555 22222222 0
hazard   1 00 06 00 0 0 0 0 00000000 0000 00 0 130 0 00 00000000 0 0 1 00 0 55555555 00000000 0
hazard   1 00 06 00 0 0 0 0 00000000 0000 00 0 130 1 06 66666666 0 1 0 00 0 00000000 00000000 0
squash   1 01 02 00 0 0 0 0 00000000 0040 00 1 134 0 00 00000000 0 1 1 00 0 00000000 66666666 0
squash   1 01 00 07 1 1 0 0 00000007 0000 00 0 138 0 00 00000000 1 1 1 00 0 11111111 22222222 1
squash   1 02 00 00 0 0 0 0 00000000 0000 00 0 13c 0 00 00000000 0 1 0 00 0 00000000 00000000 0
squash   1 07 07 00 0 0 0 0 00000000 0000 00 0 140 0 00 00000000 0 1 0 00 0 00000000 00000000 0
flow     1 03 04 08 1 0 3 2 00000000 0010 00 0 200 0 00 00000000 0 1 1 00 0 00000000 00000000 0
flow     1 01 02 09 1 1 4 3 00000099 0020 00 1 204 0 00 00000000 0 1 1 08 1 33333333 44444444 0
flow     1 02 05 0a 1 2 5 4 00000000 0030 03 0 208 0 00 00000000 0 1 1 09 1 11111111 00000099 1
flow     0 00 00 00 0 0 0 0 00000000 0000 00 0 000 1 08 88888888 0 1 1 0a 1 22222222 00000003 0
flow     0 00 00 00 0 0 0 0 00000000 0000 00 0 000 1 09 99999999 0 1 0 00 0 00000000 00000000 0
flow     0 00 00 00 0 0 0 0 00000000 0000 00 0 000 1 0a aaaaaaaa 0 1 0 00 0 00000000 00000000 0
flow     1 08 09 00 0 0 0 0 00000000 0000 00 0 20c 0 00 00000000 0 1 0 00 0 00000000 00000000 0
flow     1 0a 00 00 0 0 0 0 00000000 0000 00 0 210 0 00 00000000 0 1 1 00 0 88888888 99999999 0
flow     0 00 00 00 0 0 0 0 00000000 0000 00 0 000 0 00 00000000 0 1 1 00 0 aaaaaaaa 00000000 0
flow     0 00 00 00 0 0 0 0 00000000 0000 00 0 000 0 00 00000000 0 1 0 00 0 00000000 00000000 0

// ==== tb.f ====
common/issue_pkg.sv
hdl/regfile.sv
issue_stage/scoreboard.sv
issue_stage/issue_stage.sv
hdl/issue_top.sv
dv/issue_sva.sv
dv/tb_issue.sv
